/* hw/aging_pkg.sv */
`default_nettype none

package aging_pkg;

  // Activity count and core index widths
  parameter int CNT_W     = 8;
  parameter int CORE_ID_W = 3;  // Room for up to 8 cores

  // Unsigned count, saturates at all ones (255)
  typedef logic [CNT_W-1:0] cnt_t;

  typedef logic [CORE_ID_W-1:0] core_id_t;

  // Pulse pair raised by one core, each bit a one-cycle strobe
  typedef struct packed {
    logic alu;     // One cycle of ALU activity
    logic retire;  // One retired instruction
  } mon_pulse_t;

  // Totals of one core over one measurement window
  typedef struct packed {
    cnt_t alu_cnt;
    cnt_t retire_cnt;
  } core_cnt_t;

  // One output record, 19 bits
  typedef struct packed {
    core_id_t core_id;
    cnt_t     alu_cnt;
    cnt_t     retire_cnt;
  } aging_rec_t;

endpackage

`default_nettype wire

/* hw/monitor_sync.sv */
`timescale 1ns/100ps
`default_nettype none

// Front stage of the aging monitor
// Registers the per-core pulse lines once and times the measurement windows.
// The window counter holds the number of samples taken in the current window,
// so it reads 1 after the first sample and WINDOW_CYCLES after the last one.
module monitor_sync
  import aging_pkg::*;
#(
  parameter int N_CORES       = 5,
  parameter int WINDOW_CYCLES = 300
) (
  input  wire                             cpu_clk,
  input  wire                             i_rst,
  input  wire mon_pulse_t [N_CORES-1:0]   i_mon,         // Raw pulses from the cores
  output mon_pulse_t      [N_CORES-1:0]   o_mon,         // Same pulses, one cycle later
  output logic                            o_window_end   // High the cycle after a window
);

  localparam int CYC_W = $clog2(WINDOW_CYCLES + 1);

  localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(WINDOW_CYCLES);
  localparam logic [CYC_W-1:0] CYC_FIRST = CYC_W'(1);

  logic [CYC_W-1:0] cyc_cnt;
  logic [CYC_W-1:0] cyc_nxt;

  // Pulse register, one stage for every core lane
  always_ff @(posedge cpu_clk) begin
    if (i_rst) begin
      o_mon <= '0;
    end else begin
      o_mon <= i_mon;
    end
  end

  // Count of samples in the current window, wraps back to 1
  assign cyc_nxt = (cyc_cnt == CYC_LAST) ? CYC_FIRST : cyc_cnt + 1'b1;

  always_ff @(posedge cpu_clk) begin
    if (i_rst) begin
      cyc_cnt      <= '0;  // First edge out of reset takes sample 1
      o_window_end <= 1'b0;
    end else begin
      cyc_cnt      <= cyc_nxt;
      // The last sample of a window lands on the edge that raises the strobe,
      // so the strobe lines up with that sample leaving o_mon
      o_window_end <= (cyc_nxt == CYC_LAST);
    end
  end

endmodule

`default_nettype wire

/* hw/activity_counter.sv */
`timescale 1ns/100ps
`default_nettype none

// Activity counters for a single core
// Two saturating counts, one for ALU cycles and one for retired instructions.
// At a window end the totals go to the snapshot and the counts restart at zero.
module activity_counter
  import aging_pkg::*;
(
  input  wire              cpu_clk,
  input  wire              i_rst,
  input  wire mon_pulse_t  i_mon,          // Registered pulse pair of this core
  input  wire              i_window_end,   // Last pulse of the window is on i_mon
  output core_cnt_t        o_snap,         // Totals of the last finished window
  output logic             o_snap_vld      // One cycle, new snapshot on o_snap
);

  localparam cnt_t CNT_MAX = '1;

  cnt_t alu_cnt;
  cnt_t retire_cnt;
  cnt_t alu_nxt;
  cnt_t retire_nxt;

  // Add one pulse, hold at the top value
  function automatic cnt_t sat_add(input cnt_t cnt, input logic pulse);
    if (pulse && (cnt != CNT_MAX)) begin
      return cnt + cnt_t'(1);
    end
    return cnt;
  endfunction

  // Totals including the pulse of this cycle
  assign alu_nxt    = sat_add(alu_cnt, i_mon.alu);
  assign retire_nxt = sat_add(retire_cnt, i_mon.retire);

  always_ff @(posedge cpu_clk) begin
    if (i_rst) begin
      alu_cnt    <= '0;
      retire_cnt <= '0;
      o_snap     <= '0;
      o_snap_vld <= 1'b0;
    end else if (i_window_end) begin
      // Close the window and start the next one from zero
      o_snap.alu_cnt    <= alu_nxt;
      o_snap.retire_cnt <= retire_nxt;
      alu_cnt           <= '0;
      retire_cnt        <= '0;
      o_snap_vld        <= 1'b1;
    end else begin
      alu_cnt    <= alu_nxt;
      retire_cnt <= retire_nxt;
      o_snap_vld <= 1'b0;  // o_snap keeps its value
    end
  end

endmodule

`default_nettype wire

/* hw/report_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

// Report stage
// After each window end, reads the per-core snapshots out one per cycle,
// in core order from 0 upward, each record tagged with its core index.
// There is no back-pressure on the output, a record is valid for one cycle.
module report_sequencer
  import aging_pkg::*;
#(
  parameter int N_CORES = 5
) (
  input  wire                            cpu_clk,
  input  wire                            i_rst,
  input  wire core_cnt_t [N_CORES-1:0]   i_snap,       // Snapshots of all cores
  input  wire                            i_snap_vld,   // New snapshots this cycle
  output logic                           o_rec_vld,
  output aging_rec_t                     o_rec
);

  localparam core_id_t LAST_ID = core_id_t'(N_CORES - 1);

  core_id_t idx;     // Next core to report
  core_id_t cur_id;  // Core reported on this edge
  logic     busy;    // Records of a window still pending
  logic     emit;

  // A fresh window always restarts at core 0
  assign cur_id = i_snap_vld ? '0 : idx;
  assign emit   = i_snap_vld | busy;

  // Control path
  always_ff @(posedge cpu_clk) begin
    if (i_rst) begin
      idx       <= '0;
      busy      <= 1'b0;
      o_rec_vld <= 1'b0;
    end else if (emit) begin
      o_rec_vld <= 1'b1;
      idx       <= cur_id + 1'b1;
      busy      <= (cur_id != LAST_ID);  // Stop after the last core
    end else begin
      o_rec_vld <= 1'b0;
    end
  end

  // Record payload, only loaded while records go out
  always_ff @(posedge cpu_clk) begin
    if (emit) begin
      o_rec.core_id    <= cur_id;
      o_rec.alu_cnt    <= i_snap[cur_id].alu_cnt;
      o_rec.retire_cnt <= i_snap[cur_id].retire_cnt;
    end
  end

endmodule

`default_nettype wire

/* hw/aging_monitor_top.sv */
`timescale 1ns/100ps
`default_nettype none

// Aging activity monitor, top level
// Pulse register and window timer, one activity counter per core and the
// report stage that turns the window snapshots into a stream of records.
module aging_monitor_top
  import aging_pkg::*;
#(
  parameter int N_CORES       = 5,
  parameter int WINDOW_CYCLES = 300   // Must exceed N_CORES + 2
) (
  input  wire                            cpu_clk,
  input  wire                            i_rst,
  input  wire mon_pulse_t [N_CORES-1:0]  i_mon,       // ALU and retire pulses per core
  output logic                           o_rec_vld,
  output aging_rec_t                     o_rec
);

  mon_pulse_t [N_CORES-1:0] mon_q;       // Registered pulses
  logic                     window_end;
  core_cnt_t  [N_CORES-1:0] snap;        // Last window totals per core
  logic                     snap_vld;

  monitor_sync #(
    .N_CORES       (N_CORES),
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) u_monitor_sync (
    .cpu_clk      (cpu_clk),
    .i_rst        (i_rst),
    .i_mon        (i_mon),
    .o_mon        (mon_q),
    .o_window_end (window_end)
  );

  // All counters latch on the same edge, so the strobe of core 0
  // stands for every snapshot
  genvar g;
  for (g = 0; g < N_CORES; g++) begin : g_core
    if (g == 0) begin : g_lead
      activity_counter u_activity_counter (
        .cpu_clk      (cpu_clk),
        .i_rst        (i_rst),
        .i_mon        (mon_q[g]),
        .i_window_end (window_end),
        .o_snap       (snap[g]),
        .o_snap_vld   (snap_vld)
      );
    end else begin : g_follow
      activity_counter u_activity_counter (
        .cpu_clk      (cpu_clk),
        .i_rst        (i_rst),
        .i_mon        (mon_q[g]),
        .i_window_end (window_end),
        .o_snap       (snap[g]),
        .o_snap_vld   ()            // Same timing as core 0
      );
    end
  end

  report_sequencer #(
    .N_CORES (N_CORES)
  ) u_report_sequencer (
    .cpu_clk    (cpu_clk),
    .i_rst      (i_rst),
    .i_snap     (snap),
    .i_snap_vld (snap_vld),
    .o_rec_vld  (o_rec_vld),
    .o_rec      (o_rec)
  );

endmodule

`default_nettype wire

/* testbench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Ends the run at the first error
task automatic abort_run(input string why);
  $display("%s", why);
  $display("sim failed");
  $fatal(1, "Run stopped at the first error");
endtask

function automatic string rec_text(input aging_rec_t rec);
  return $sformatf("core %0d alu %0d retire %0d", rec.core_id, rec.alu_cnt, rec.retire_cnt);
endfunction

// One output record against the value derived from the vectors
task automatic check_rec(input string name, input aging_rec_t exp_rec,
                         input aging_rec_t act_rec);
  if (act_rec !== exp_rec) begin
    abort_run($sformatf("ERR %s expected %s, actual %s", name, rec_text(exp_rec),
                        rec_text(act_rec)));
  end
endtask

// Number of records seen for one window
task automatic check_count(input string name, input cnt_t exp_cnt, input cnt_t act_cnt);
  if (act_cnt !== exp_cnt) begin
    abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp_cnt, act_cnt));
  end
endtask

function automatic string window_name(input int win);
  return $sformatf("window_%0d_records", win);
endfunction

`endif

/* testbench/tb_aging_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_aging_monitor
  import aging_pkg::*;
();

  localparam int    N_CORES       = 5;
  localparam int    WINDOW_CYCLES = 300;
  localparam int    MAX_WIN       = 16;
  localparam int    RST_CYCLES    = 16;
  localparam int    PULSE_START   = 4;                        // First pulse cycle in a window
  localparam int    MAX_ALU       = WINDOW_CYCLES - 2 * PULSE_START;
  localparam int    MAX_RET       = MAX_ALU / 2;              // Retire pulses every other cycle
  localparam real   CLK_PERIOD    = 4.0;
  localparam real   DRIVE_DLY     = 0.5;
  localparam string VEC_FILE      = "testbench/aging_vectors.txt";

  logic                     cpu_clk;
  logic                     i_rst;
  mon_pulse_t [N_CORES-1:0] i_mon;
  logic                     o_rec_vld;
  aging_rec_t               o_rec;

  int    vec_alu  [MAX_WIN][N_CORES];
  int    vec_ret  [MAX_WIN][N_CORES];
  string vec_name [MAX_WIN][N_CORES];
  int    rec_cnt  [MAX_WIN];        // Records seen per window
  int    n_win;
  bit    vec_loaded = 1'b0;
  int    edge_no;                   // Rising edges since reset was released
  int    rec_total  = 0;

  `include "tb_checks.svh"

  aging_monitor_top #(
    .N_CORES       (N_CORES),
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) aging_monitor_top_i (
    .cpu_clk   (cpu_clk),
    .i_rst     (i_rst),
    .i_mon     (i_mon),
    .o_rec_vld (o_rec_vld),
    .o_rec     (o_rec)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
  end

  always @(posedge cpu_clk) begin
    if (i_rst) begin
      edge_no <= 0;
    end else begin
      edge_no <= edge_no + 1;
    end
  end

  function automatic cnt_t clip_count(input int cnt);
    int cnt_max;
    cnt_max = (1 << CNT_W) - 1;
    if (cnt > cnt_max) begin
      return cnt_t'(cnt_max);
    end
    return cnt_t'(cnt);
  endfunction

  function automatic aging_rec_t expected_rec(input int win, input int core);
    aging_rec_t rec;
    rec.core_id    = core_id_t'(core);
    rec.alu_cnt    = clip_count(vec_alu[win][core]);
    rec.retire_cnt = clip_count(vec_ret[win][core]);
    return rec;
  endfunction

  // ALU pulses back to back, retire pulses every other cycle
  function automatic mon_pulse_t pulse_at(input int win, input int core, input int cyc);
    mon_pulse_t p;
    int         ofs;
    ofs      = cyc - PULSE_START;
    p.alu    = (ofs >= 0) && (ofs < vec_alu[win][core]);
    p.retire = (ofs >= 0) && (ofs % 2 == 0) && (ofs / 2 < vec_ret[win][core]);
    return p;
  endfunction

  task automatic load_vectors();
    int               fd;
    int               code;
    int               win;
    int               core;
    int               alu;
    int               ret;
    logic [8*256-1:0] line;
    logic [8*32-1:0]  name_raw;
    for (int k = 0; k < MAX_WIN; k++) begin
      rec_cnt[k] = 0;
      for (int c = 0; c < N_CORES; c++) begin
        vec_alu[k][c]  = 0;
        vec_ret[k][c]  = 0;
        vec_name[k][c] = "unnamed";
      end
    end
    n_win = 0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("Could not open the vector file %s", VEC_FILE));
    end
    while ($fgets(line, fd) != 0) begin
      name_raw = '0;
      code = $sscanf(line, "%d %d %d %d %s", win, core, alu, ret, name_raw);
      if (code != 5) begin
        continue;  // Comment or blank line
      end
      if (win < 0 || win >= MAX_WIN || core < 0 || core >= N_CORES) begin
        abort_run($sformatf("Vector for window %0d core %0d is out of range", win, core));
      end else if (alu > MAX_ALU || ret > MAX_RET) begin
        abort_run($sformatf("Pulse counts of window %0d core %0d do not fit a window",
                            win, core));
      end else begin
        vec_alu[win][core]  = alu;
        vec_ret[win][core]  = ret;
        vec_name[win][core] = string'(name_raw);
        if (win + 1 > n_win) begin
          n_win = win + 1;
        end
      end
    end
    $fclose(fd);
    if (n_win == 0) begin
      abort_run("The vector file holds no vectors");
    end
  endtask

  task automatic drive_window_cycle(input int win, input int cyc);
    mon_pulse_t [N_CORES-1:0] pulses;
    for (int c = 0; c < N_CORES; c++) begin
      pulses[c] = pulse_at(win, c, cyc);
    end
    i_mon = pulses;
  endtask

  initial begin : drive_stimulus
    i_rst = 1'b1;
    i_mon = '0;
    load_vectors();
    vec_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge cpu_clk);
    #(DRIVE_DLY);
    i_rst = 1'b0;
    // Value set here is sampled by the next rising edge
    for (int k = 0; k < n_win; k++) begin
      for (int cyc = 1; cyc <= WINDOW_CYCLES; cyc++) begin
        drive_window_cycle(k, cyc);
        @(posedge cpu_clk);
        #(DRIVE_DLY);
      end
    end
    i_mon = '0;
    wait (rec_total >= n_win * N_CORES);
    repeat (N_CORES + 1) @(negedge cpu_clk);  // Catch a stray extra record
    $display("sim passed");
    $finish;
  end

  // Records of window k leave at edges (k+1)*W+2 onward, one per cycle
  initial begin : collect_records
    int win;
    int pos;
    int exp_edge;
    forever begin
      @(negedge cpu_clk);
      if (!i_rst && o_rec_vld) begin
        win = (edge_no - 2) / WINDOW_CYCLES - 1;
        if (win < 0) begin
          abort_run($sformatf("A record came out at edge %0d, before any window had ended",
                              edge_no));
        end else if (win < n_win) begin
          pos      = rec_cnt[win];
          exp_edge = (win + 1) * WINDOW_CYCLES + 2 + pos;
          if (pos == 0 && win > 0) begin
            // Previous window must be complete before this one starts
            check_count(window_name(win - 1), cnt_t'(N_CORES), cnt_t'(rec_cnt[win - 1]));
          end
          if (pos >= N_CORES) begin
            check_count(window_name(win), cnt_t'(N_CORES), cnt_t'(pos + 1));
          end else if (edge_no != exp_edge) begin
            abort_run($sformatf("Record %0d of window %0d came at edge %0d, not at edge %0d",
                                pos, win, edge_no, exp_edge));
          end else begin
            check_rec(vec_name[win][pos], expected_rec(win, pos), o_rec);
          end
          rec_cnt[win] = pos + 1;
          rec_total++;
        end
      end
    end
  end

  initial begin : watchdog
    wait (vec_loaded);
    #((n_win + 2) * WINDOW_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Timeout, the records of %0d windows did not all arrive", n_win));
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+testbench
hw/aging_pkg.sv
hw/monitor_sync.sv
hw/activity_counter.sv
hw/report_sequencer.sv
hw/aging_monitor_top.sv
testbench/tb_aging_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build the aging monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_aging_monitor -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_aging_monitor 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'sim passed'; then
  exit 0
else
  exit 1
fi

/* testbench/aging_vectors.txt */
# Columns: window core alu_pulses retire_pulses test_name
# ALU up to 292 and retire up to 146 per window, reported counts clip at 255
0 0 0 0 reset_idle
0 1 0 0 reset_idle
0 2 0 0 reset_idle
0 3 0 0 reset_idle
0 4 0 0 reset_idle
1 0 10 3 lane_map
1 1 20 7 lane_map
1 2 35 11 lane_map
1 3 50 19 lane_map
1 4 65 23 lane_map
2 0 292 100 alu_saturate
2 1 255 146 max_exact
2 2 256 1 one_over
2 3 0 146 retire_only
2 4 7 0 alu_only
3 0 0 0 idle_after_busy
3 1 0 0 idle_after_busy
3 2 0 0 idle_after_busy
3 3 0 0 idle_after_busy
3 4 0 0 idle_after_busy
4 0 0 0 small_steps
4 1 1 1 small_steps
4 2 2 2 small_steps
4 3 3 3 small_steps
4 4 4 4 small_steps
5 0 292 146 full_load
5 1 292 146 full_load
5 2 292 146 full_load
5 3 292 146 full_load
5 4 292 146 full_load
6 0 0 0 idle_after_full
6 1 0 0 idle_after_full
6 2 0 0 idle_after_full
6 3 0 0 idle_after_full
6 4 0 0 idle_after_full
7 0 100 50 alternate
7 1 0 0 alternate
7 2 200 99 alternate
7 3 0 0 alternate
7 4 150 75 alternate
8 0 1 0 single_pulse
8 1 0 1 single_pulse
8 2 1 1 single_pulse
8 3 0 0 single_pulse
8 4 1 0 single_pulse
9 0 254 127 near_max
9 1 255 128 near_max
9 2 256 129 near_max
9 3 257 130 near_max
9 4 291 145 near_max
10 0 5 140 mixed
10 1 60 60 mixed
10 2 120 30 mixed
10 3 180 15 mixed
10 4 240 5 mixed
11 0 0 0 final_idle
11 1 0 0 final_idle
11 2 0 0 final_idle
11 3 0 0 final_idle
11 4 0 0 final_idle
